//--- sources.f
rab_pkg.sv
axi_buffer_rab.sv
rab_slice_table.sv
rab_remap.sv
rab_core.sv
tb_rab_core.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

LOG=sim.log
BUILD_DIR=obj_dir
EXE=sim_rab_core

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_rab_core \
    -Mdir "$BUILD_DIR" -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- tb_rab_core.sv
module tb_rab_core;

    import rab_pkg::*;

    // ------------------------------
    // Run constants
    // ------------------------------

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 90871;
    localparam int N_TESTS      = 16;
    // Free output in the first pass and back-pressure in the second
    localparam int N_PASSES     = 2;
    // Four fields for each of the four slices
    localparam int N_CFG_WRITES = 4 * N_SLICES;
    // Output held low this long before random ready
    localparam int STALL_CYCLES = 20;
    localparam int TIMEOUT_CYCLES = 10 * N_TESTS * N_PASSES + N_CFG_WRITES + RESET_CYCLES;

    logic                       clk;
    logic                       rstn;
    logic                       cfg_we;
    logic [SLICE_IDX_WIDTH-1:0] cfg_slice;
    rab_cfg_field_e             cfg_field;
    logic [ADDR_WIDTH-1:0]      cfg_wdata;
    logic                       in_valid;
    logic [ID_WIDTH-1:0]        in_id;
    logic [ADDR_WIDTH-1:0]      in_addr;
    logic                       in_write;
    logic                       in_ready;
    logic                       out_valid;
    logic [ID_WIDTH-1:0]        out_id;
    logic [ADDR_WIDTH-1:0]      out_addr;
    rab_result_e                out_result;
    logic                       out_ready;

    // One row of stimulus and expected values per test
    string                 test_name  [N_TESTS];
    logic [ID_WIDTH-1:0]   test_id    [N_TESTS];
    logic [ADDR_WIDTH-1:0] test_addr  [N_TESTS];
    logic                  test_write [N_TESTS];
    logic [ADDR_WIDTH-1:0] exp_addr   [N_TESTS];
    rab_result_e           exp_result [N_TESTS];
    int                    n_loaded;

    int error_count;
    int check_count;
    int cycle_count;
    bit rx_done;
    bit saw_in_ready_low;

    rab_core uut (
        .clk        (clk),
        .rstn       (rstn),
        .cfg_we     (cfg_we),
        .cfg_slice  (cfg_slice),
        .cfg_field  (cfg_field),
        .cfg_wdata  (cfg_wdata),
        .in_valid   (in_valid),
        .in_id      (in_id),
        .in_addr    (in_addr),
        .in_write   (in_write),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_id     (out_id),
        .out_addr   (out_addr),
        .out_result (out_result),
        .out_ready  (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Cycle limit for the whole run
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: no result after %0d cycles, pipeline stuck", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ------------------------------
    // Table
    // ------------------------------

    task automatic add_entry(input string name, input logic [ID_WIDTH-1:0] id,
                             input logic [ADDR_WIDTH-1:0] addr, input logic write,
                             input logic [ADDR_WIDTH-1:0] xaddr, input rab_result_e xres);
        test_name[n_loaded]  = name;
        test_id[n_loaded]    = id;
        test_addr[n_loaded]  = addr;
        test_write[n_loaded] = write;
        exp_addr[n_loaded]   = xaddr;
        exp_result[n_loaded] = xres;
        n_loaded++;
    endtask

    // Slice 0 maps 1000_0000..1000_0FFF to 8000_0000 for read and write
    // Slice 1 maps 1000_0800..1000_1FFF to 9000_0000 for write only
    // Slice 2 maps 2000_0000..2000_FFFF to A000_0000 for read only
    // Slice 3 covers 3000_0000..3000_FFFF with rights set but stays disabled
    task automatic load_table();
        n_loaded = 0;
        add_entry("rd_s0",         4'h1, 32'h1000_0010, 1'b0, 32'h8000_0010, RAB_HIT);
        add_entry("wr_s0",         4'h2, 32'h1000_0020, 1'b1, 32'h8000_0020, RAB_HIT);
        add_entry("s0_start",      4'h3, 32'h1000_0000, 1'b0, 32'h8000_0000, RAB_HIT);
        add_entry("s0_end",        4'h4, 32'h1000_0FFF, 1'b1, 32'h8000_0FFF, RAB_HIT);
        // Slice 0 wins where it overlaps slice 1
        add_entry("overlap_rd",    4'h5, 32'h1000_0900, 1'b0, 32'h8000_0900, RAB_HIT);
        add_entry("overlap_s1_lo", 4'h6, 32'h1000_0800, 1'b1, 32'h8000_0800, RAB_HIT);
        add_entry("wr_s1",         4'h7, 32'h1000_1004, 1'b1, 32'h9000_0804, RAB_HIT);
        add_entry("s1_end",        4'h8, 32'h1000_1FFF, 1'b1, 32'h9000_17FF, RAB_HIT);
        add_entry("rd_wo_prot",    4'h9, 32'h1000_1100, 1'b0, 32'h1000_1100, RAB_PROT);
        add_entry("rd_s2",         4'hA, 32'h2000_0040, 1'b0, 32'hA000_0040, RAB_HIT);
        add_entry("s2_end",        4'hB, 32'h2000_FFFF, 1'b0, 32'hA000_FFFF, RAB_HIT);
        add_entry("wr_ro_prot",    4'hC, 32'h2000_0044, 1'b1, 32'h2000_0044, RAB_PROT);
        add_entry("disabled_miss", 4'hD, 32'h3000_0010, 1'b0, 32'h3000_0010, RAB_MISS);
        add_entry("outside_miss",  4'hE, 32'h5000_0000, 1'b1, 32'h5000_0000, RAB_MISS);
        add_entry("below_miss",    4'hF, 32'h0FFF_FFFF, 1'b0, 32'h0FFF_FFFF, RAB_MISS);
        add_entry("above_s2_miss", 4'h0, 32'h2001_0000, 1'b0, 32'h2001_0000, RAB_MISS);
    endtask

    // ------------------------------
    // Configuration
    // ------------------------------

    // One write per edge when entered just after a rising edge
    task automatic write_cfg(input int slice, input rab_cfg_field_e field,
                             input logic [ADDR_WIDTH-1:0] data);
        cfg_we    = 1'b1;
        cfg_slice = SLICE_IDX_WIDTH'(slice);
        cfg_field = field;
        cfg_wdata = data;
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_we    = 1'b0;
    endtask

    task automatic program_slice(input int slice, input logic [ADDR_WIDTH-1:0] first,
                                 input logic [ADDR_WIDTH-1:0] last,
                                 input logic [ADDR_WIDTH-1:0] target, input logic [2:0] flags);
        write_cfg(slice, CFG_START, first);
        write_cfg(slice, CFG_END, last);
        write_cfg(slice, CFG_OFFSET, target);
        // Flags bit 0 enable, bit 1 read, bit 2 write
        write_cfg(slice, CFG_FLAGS, {29'd0, flags});
    endtask

    // ------------------------------
    // Driver, monitor, ready control
    // ------------------------------

    // Valid stays high until the buffer takes the entry
    task automatic send_table();
        bit accepted;
        for (int i = 0; i < N_TESTS; i++)
        begin
            in_valid = 1'b1;
            in_id    = test_id[i];
            in_addr  = test_addr[i];
            in_write = test_write[i];
            accepted = 1'b0;
            while (!accepted)
            begin
                // Inputs are settled mid-cycle so the handshake is known here
                @(negedge clk);
                accepted = in_ready;
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic check_entry(input int idx);
        check_count += 3;
        assert (out_id === test_id[idx])
        else
        begin
            $display("Error: %s id expected %h actual %h", test_name[idx], test_id[idx], out_id);
            error_count++;
        end
        assert (out_addr === exp_addr[idx])
        else
        begin
            $display("Error: %s addr expected %h actual %h", test_name[idx], exp_addr[idx],
                     out_addr);
            error_count++;
        end
        assert (out_result === exp_result[idx])
        else
        begin
            $display("Error: %s result expected %s actual %s", test_name[idx],
                     exp_result[idx].name(), out_result.name());
            error_count++;
        end
    endtask

    // Output transfers must match the table in order
    task automatic collect_outputs();
        int idx;
        idx = 0;
        while (idx < N_TESTS)
        begin
            @(negedge clk);
            if (out_valid && out_ready)
            begin
                check_entry(idx);
                idx++;
            end
        end
        // Let the last transfer complete
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_back_pressure();
        out_ready = 1'b0;
        repeat (STALL_CYCLES)
        begin
            @(negedge clk);
            if (!in_ready)
                saw_in_ready_low = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        // Random ready until everything has drained
        while (!rx_done)
        begin
            out_ready = 1'($urandom());
            @(posedge clk);
            #DRIVE_DELAY;
        end
        out_ready = 1'b1;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial
    begin
        void'($urandom(SEED));
        clk              = 1'b0;
        rstn             = 1'b0;
        cfg_we           = 1'b0;
        cfg_slice        = '0;
        cfg_field        = CFG_START;
        cfg_wdata        = '0;
        in_valid         = 1'b0;
        in_id            = '0;
        in_addr          = '0;
        in_write         = 1'b0;
        out_ready        = 1'b1;
        error_count      = 0;
        check_count      = 0;
        rx_done          = 1'b0;
        saw_in_ready_low = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;

        check_count += 2;
        assert (out_valid === 1'b0)
        else
        begin
            $display("Output valid is not low after reset");
            error_count++;
        end
        assert (in_ready === 1'b1)
        else
        begin
            $display("Input ready is not high after reset");
            error_count++;
        end

        load_table();
        program_slice(0, 32'h1000_0000, 32'h1000_0FFF, 32'h8000_0000, 3'b111);
        program_slice(1, 32'h1000_0800, 32'h1000_1FFF, 32'h9000_0000, 3'b101);
        program_slice(2, 32'h2000_0000, 32'h2000_FFFF, 32'hA000_0000, 3'b011);
        program_slice(3, 32'h3000_0000, 32'h3000_FFFF, 32'hB000_0000, 3'b110);

        // Free-running output
        fork
            send_table();
            collect_outputs();
        join

        // Same table with the output stalled and then random ready
        fork
            send_table();
            begin
                collect_outputs();
                rx_done = 1'b1;
            end
            apply_back_pressure();
        join

        check_count++;
        assert (saw_in_ready_low)
        else
        begin
            $display("Input ready never fell while the output was stalled");
            error_count++;
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- rab_core.sv
module rab_core
(
    input  logic                                clk,
    input  logic                                rstn,

    // Slice configuration
    input  logic                                cfg_we,
    input  logic [rab_pkg::SLICE_IDX_WIDTH-1:0] cfg_slice,
    input  rab_pkg::rab_cfg_field_e             cfg_field,
    input  logic [rab_pkg::ADDR_WIDTH-1:0]      cfg_wdata,

    // Incoming address requests
    input  logic                                in_valid,
    input  logic [rab_pkg::ID_WIDTH-1:0]        in_id,
    input  logic [rab_pkg::ADDR_WIDTH-1:0]      in_addr,
    input  logic                                in_write,
    output logic                                in_ready,

    // Translated requests
    output logic                                out_valid,
    output logic [rab_pkg::ID_WIDTH-1:0]        out_id,
    output logic [rab_pkg::ADDR_WIDTH-1:0]      out_addr,
    output rab_pkg::rab_result_e                out_result,
    input  logic                                out_ready
);

    import rab_pkg::*;

    // Input buffer hops
    logic [REQ_WIDTH-1:0] in_data;
    logic                 req_valid;
    logic [REQ_WIDTH-1:0] req_data;
    logic                 req_ready;

    // Slice table to remap
    logic                                lk_valid;
    logic [ID_WIDTH-1:0]                 lk_id;
    logic [ADDR_WIDTH-1:0]               lk_addr;
    logic                                lk_write;
    logic [N_SLICES-1:0]                 lk_hit;
    logic [N_SLICES-1:0][ADDR_WIDTH-1:0] lk_start;
    logic [N_SLICES-1:0][ADDR_WIDTH-1:0] lk_offset;
    logic [N_SLICES-1:0][FLAG_WIDTH-1:0] lk_flags;
    logic                                lk_ready;

    // Remap to output buffer
    logic                 rm_valid;
    logic [RSP_WIDTH-1:0] rm_data;
    logic                 rm_ready;
    logic [RSP_WIDTH-1:0] out_data;

    // ------------------------------
    // Input buffer
    // ------------------------------

    assign in_data = {in_id, in_addr, in_write};

    axi_buffer_rab #(
        .DATA_WIDTH       (REQ_WIDTH),
        .BUFFER_DEPTH     (BUFFER_DEPTH),
        .LOG_BUFFER_DEPTH (LOG_BUFFER_DEPTH)
    ) u_buf_in (
        .clk       (clk),
        .rstn      (rstn),
        .data_out  (req_data),
        .valid_out (req_valid),
        .ready_in  (req_ready),
        .valid_in  (in_valid),
        .data_in   (in_data),
        .ready_out (in_ready)
    );

    // ------------------------------
    // Lookup and remap
    // ------------------------------

    rab_slice_table u_slice_table (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_we    (cfg_we),
        .cfg_slice (cfg_slice),
        .cfg_field (cfg_field),
        .cfg_wdata (cfg_wdata),
        .req_valid (req_valid),
        .req_data  (req_data),
        .req_ready (req_ready),
        .lk_valid  (lk_valid),
        .lk_id     (lk_id),
        .lk_addr   (lk_addr),
        .lk_write  (lk_write),
        .lk_hit    (lk_hit),
        .lk_start  (lk_start),
        .lk_offset (lk_offset),
        .lk_flags  (lk_flags),
        .lk_ready  (lk_ready)
    );

    rab_remap u_remap (
        .clk       (clk),
        .rstn      (rstn),
        .lk_valid  (lk_valid),
        .lk_id     (lk_id),
        .lk_addr   (lk_addr),
        .lk_write  (lk_write),
        .lk_hit    (lk_hit),
        .lk_start  (lk_start),
        .lk_offset (lk_offset),
        .lk_flags  (lk_flags),
        .lk_ready  (lk_ready),
        .rm_valid  (rm_valid),
        .rm_data   (rm_data),
        .rm_ready  (rm_ready)
    );

    // ------------------------------
    // Output buffer
    // ------------------------------

    axi_buffer_rab #(
        .DATA_WIDTH       (RSP_WIDTH),
        .BUFFER_DEPTH     (BUFFER_DEPTH),
        .LOG_BUFFER_DEPTH (LOG_BUFFER_DEPTH)
    ) u_buf_out (
        .clk       (clk),
        .rstn      (rstn),
        .data_out  (out_data),
        .valid_out (out_valid),
        .ready_in  (out_ready),
        .valid_in  (rm_valid),
        .data_in   (rm_data),
        .ready_out (rm_ready)
    );

    // Unpack {id, addr, result}
    assign out_id     = out_data[RSP_WIDTH-1 -: ID_WIDTH];
    assign out_addr   = out_data[2 +: ADDR_WIDTH];
    assign out_result = rab_result_e'(out_data[1:0]);

endmodule

//--- rab_remap.sv
module rab_remap
(
    input  logic                                                  clk,
    input  logic                                                  rstn,

    // Lookup from the slice table
    input  logic                                                  lk_valid,
    input  logic [rab_pkg::ID_WIDTH-1:0]                          lk_id,
    input  logic [rab_pkg::ADDR_WIDTH-1:0]                        lk_addr,
    input  logic                                                  lk_write,
    input  logic [rab_pkg::N_SLICES-1:0]                          lk_hit,
    input  logic [rab_pkg::N_SLICES-1:0][rab_pkg::ADDR_WIDTH-1:0] lk_start,
    input  logic [rab_pkg::N_SLICES-1:0][rab_pkg::ADDR_WIDTH-1:0] lk_offset,
    input  logic [rab_pkg::N_SLICES-1:0][rab_pkg::FLAG_WIDTH-1:0] lk_flags,
    output logic                                                  lk_ready,

    // Packed result towards the output buffer
    output logic                                                  rm_valid,
    output logic [rab_pkg::RSP_WIDTH-1:0]                         rm_data,
    input  logic                                                  rm_ready
);

    import rab_pkg::*;

    // Winning slice
    logic [SLICE_IDX_WIDTH-1:0] sel;
    logic                       hit_any;
    // Direction right of the winning slice
    logic                       allowed;

    logic [ADDR_WIDTH-1:0]      nxt_addr;
    rab_result_e                nxt_result;

    // ------------------------------
    // Slice priority
    // ------------------------------

    // Walk downwards so the lowest index wins
    always_comb
    begin
        sel = '0;
        for (int i = N_SLICES - 1; i >= 0; i--)
        begin
            if (lk_hit[i])
                sel = SLICE_IDX_WIDTH'(i);
        end
    end

    assign hit_any = |lk_hit;

    // Write needs the write flag, read the read flag
    assign allowed = lk_write ? lk_flags[sel][FLAG_WR] : lk_flags[sel][FLAG_RD];

    // ------------------------------
    // Translation
    // ------------------------------

    always_comb
    begin
        if (!hit_any)
        begin
            nxt_result = RAB_MISS;
            nxt_addr   = lk_addr;
        end
        else if (!allowed)
        begin
            // Address passes through untouched on a fault
            nxt_result = RAB_PROT;
            nxt_addr   = lk_addr;
        end
        else
        begin
            nxt_result = RAB_HIT;
            nxt_addr   = lk_addr - lk_start[sel] + lk_offset[sel];
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------

    assign lk_ready = !rm_valid || rm_ready;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            rm_valid <= 1'b0;
        else if (lk_ready)
            rm_valid <= lk_valid;
    end

    // Result packed as {id, addr, result}
    always_ff @(posedge clk)
    begin
        if (lk_valid && lk_ready)
            rm_data <= {lk_id, nxt_addr, nxt_result};
    end

endmodule

//--- rab_slice_table.sv
module rab_slice_table
(
    input  logic                                                  clk,
    input  logic                                                  rstn,

    // Configuration port
    input  logic                                                  cfg_we,
    input  logic [rab_pkg::SLICE_IDX_WIDTH-1:0]                   cfg_slice,
    input  rab_pkg::rab_cfg_field_e                               cfg_field,
    input  logic [rab_pkg::ADDR_WIDTH-1:0]                        cfg_wdata,

    // Packed request from the input buffer
    input  logic                                                  req_valid,
    input  logic [rab_pkg::REQ_WIDTH-1:0]                         req_data,
    output logic                                                  req_ready,

    // Registered lookup towards the remap stage
    output logic                                                  lk_valid,
    output logic [rab_pkg::ID_WIDTH-1:0]                          lk_id,
    output logic [rab_pkg::ADDR_WIDTH-1:0]                        lk_addr,
    output logic                                                  lk_write,
    output logic [rab_pkg::N_SLICES-1:0]                          lk_hit,
    output logic [rab_pkg::N_SLICES-1:0][rab_pkg::ADDR_WIDTH-1:0] lk_start,
    output logic [rab_pkg::N_SLICES-1:0][rab_pkg::ADDR_WIDTH-1:0] lk_offset,
    output logic [rab_pkg::N_SLICES-1:0][rab_pkg::FLAG_WIDTH-1:0] lk_flags,
    input  logic                                                  lk_ready
);

    import rab_pkg::*;

    // Slice registers
    logic [N_SLICES-1:0][ADDR_WIDTH-1:0] slice_start;
    logic [N_SLICES-1:0][ADDR_WIDTH-1:0] slice_end;
    logic [N_SLICES-1:0][ADDR_WIDTH-1:0] slice_offset;
    logic [N_SLICES-1:0][FLAG_WIDTH-1:0] slice_flags;

    // Unpacked request fields
    logic [ID_WIDTH-1:0]   req_id;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic                  req_write;

    // Per-slice match for the request in front
    logic [N_SLICES-1:0]   nxt_hit;

    logic accept;

    // ------------------------------
    // Configuration
    // ------------------------------

    // Address range and target base
    always_ff @(posedge clk)
    begin
        if (cfg_we && (cfg_field == CFG_START))
            slice_start[cfg_slice] <= cfg_wdata;
        if (cfg_we && (cfg_field == CFG_END))
            slice_end[cfg_slice] <= cfg_wdata;
        if (cfg_we && (cfg_field == CFG_OFFSET))
            slice_offset[cfg_slice] <= cfg_wdata;
    end

    // All slices come up disabled
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            slice_flags <= '0;
        else if (cfg_we && (cfg_field == CFG_FLAGS))
            slice_flags[cfg_slice] <= cfg_wdata[FLAG_WIDTH-1:0];
    end

    // ------------------------------
    // Range compare
    // ------------------------------

    assign req_id    = req_data[REQ_WIDTH-1 -: ID_WIDTH];
    assign req_addr  = req_data[1 +: ADDR_WIDTH];
    assign req_write = req_data[0];

    // Both range ends are inclusive
    always_comb
    begin
        for (int i = 0; i < N_SLICES; i++)
        begin
            nxt_hit[i] = slice_flags[i][FLAG_EN] &&
                         (req_addr >= slice_start[i]) &&
                         (req_addr <= slice_end[i]);
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------

    // Take a new request when empty or when the entry leaves now
    assign req_ready = !lk_valid || lk_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            lk_valid <= 1'b0;
        else if (req_ready)
            lk_valid <= req_valid;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            lk_id    <= req_id;
            lk_addr  <= req_addr;
            lk_write <= req_write;
            lk_hit   <= nxt_hit;
        end
    end

    // Slice fields needed by the remap stage
    assign lk_start  = slice_start;
    assign lk_offset = slice_offset;
    assign lk_flags  = slice_flags;

endmodule

//--- axi_buffer_rab.sv
module axi_buffer_rab
#(
    parameter int DATA_WIDTH       = 32,
    parameter int BUFFER_DEPTH     = 4,
    parameter int LOG_BUFFER_DEPTH = 2
)
(
    input  logic                  clk,
    input  logic                  rstn,

    // Downstream side, oldest entry first
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out,
    input  logic                  ready_in,

    // Upstream side
    input  logic                  valid_in,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic                  ready_out
);

    // Next slot to write
    logic [LOG_BUFFER_DEPTH-1:0] pointer_in;
    // Slot presented on data_out
    logic [LOG_BUFFER_DEPTH-1:0] pointer_out;
    // Occupancy, one bit wider than the pointers
    logic [LOG_BUFFER_DEPTH:0]   elements;
    // Storage array
    logic [DATA_WIDTH-1:0]       buffer [BUFFER_DEPTH];

    logic full;
    logic push;
    logic pop;

    assign full = (elements == (LOG_BUFFER_DEPTH + 1)'(BUFFER_DEPTH));

    // Write accepted whenever there is room
    assign push = valid_in && !full;
    // Read happens on a downstream handshake
    assign pop  = valid_out && ready_in;

    // ------------------------------
    // Occupancy counter
    // ------------------------------

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            elements <= '0;
        end
        else if (pop && !push)
        begin
            // One out, none in
            elements <= elements - 1'b1;
        end
        else if (push && !pop)
        begin
            // One in, none out
            elements <= elements + 1'b1;
        end
        // Both or neither leave the count as is
    end

    // ------------------------------
    // Storage
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            buffer[pointer_in] <= data_in;
        end
    end

    // ------------------------------
    // Pointers
    // ------------------------------

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            pointer_in  <= '0;
            pointer_out <= '0;
        end
        else
        begin
            // Input side wraps at the last slot
            if (push)
            begin
                if (pointer_in == LOG_BUFFER_DEPTH'(BUFFER_DEPTH - 1))
                    pointer_in <= '0;
                else
                    pointer_in <= pointer_in + 1'b1;
            end

            // Move on once the current entry is taken
            if (pop)
            begin
                if (pointer_out == LOG_BUFFER_DEPTH'(BUFFER_DEPTH - 1))
                    pointer_out <= '0;
                else
                    pointer_out <= pointer_out + 1'b1;
            end
        end
    end

    // Outputs
    assign data_out  = buffer[pointer_out];
    assign valid_out = (elements != '0);
    assign ready_out = !full;

endmodule

//--- rab_pkg.sv
package rab_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------

    // Request and translated address width
    localparam int ADDR_WIDTH = 32;
    // Transaction ID width
    localparam int ID_WIDTH = 4;

    // ------------------------------
    // Slice table geometry
    // ------------------------------

    localparam int N_SLICES = 4;
    localparam int SLICE_IDX_WIDTH = 2;

    // Flag bits held per slice
    localparam int FLAG_WIDTH = 3;
    localparam int FLAG_EN = 0;
    localparam int FLAG_RD = 1;
    localparam int FLAG_WR = 2;

    // ------------------------------
    // Buffers
    // ------------------------------

    // Same depth for the input and the output buffer
    localparam int BUFFER_DEPTH = 4;
    localparam int LOG_BUFFER_DEPTH = 2;

    // Request packing is {id, addr, write}
    localparam int REQ_WIDTH = ID_WIDTH + ADDR_WIDTH + 1;
    // Result packing is {id, addr, result}
    localparam int RSP_WIDTH = ID_WIDTH + ADDR_WIDTH + 2;

    // Outcome of the slice lookup
    typedef enum logic [1:0] {
        RAB_HIT  = 2'd0,
        RAB_MISS = 2'd1,
        RAB_PROT = 2'd2
    } rab_result_e;

    // Slice register selected by a configuration write
    typedef enum logic [1:0] {
        CFG_START  = 2'd0,
        CFG_END    = 2'd1,
        CFG_OFFSET = 2'd2,
        CFG_FLAGS  = 2'd3
    } rab_cfg_field_e;

endpackage
